//--- design/codec_pkg.sv
package codec_pkg;

    //////////////////////////////////////////////////
    // control port framing
    //////////////////////////////////////////////////
    localparam int CMD_BITS  = 32;
    localparam int CCLK_DIV  = 4;
    localparam int LATCH_GAP = 8;
    localparam int CMD_COUNT = 12;

    localparam int CCLK_PHASE_W = $clog2(CCLK_DIV);
    localparam int BIT_CNT_W    = $clog2(CMD_BITS);
    localparam int GAP_CNT_W    = $clog2(LATCH_GAP);
    localparam int CMD_IDX_W    = $clog2(CMD_COUNT);

    // chip address byte: r/w in bit 0, address pins tied low
    typedef struct packed {
        logic [7:0]  chip_addr;
        logic [15:0] reg_addr;
        logic [7:0]  data;
    } codec_fields_t;

    typedef union packed {
        logic [CMD_BITS-1:0] raw;
        codec_fields_t       f;
    } codec_cmd_u;

    // three dummy writes first, clatch toggles put the codec in spi mode
    // then clocks, serial port, dac, playback mixers, hp volume, dsp run
    localparam codec_cmd_u CMD_TABLE [CMD_COUNT] = '{
        32'h00_4000_00, 32'h00_4000_00, 32'h00_4000_00,
        32'h00_4000_01, 32'h00_4015_00, 32'h00_4016_00,
        32'h00_402A_03, 32'h00_401C_21, 32'h00_401E_41,
        32'h00_4023_E7, 32'h00_4024_E7, 32'h00_40F6_01
    };

endpackage

//--- design/audio_pkg.sv
package audio_pkg;

    //////////////////////////////////////////////////
    // sample and frame types
    //////////////////////////////////////////////////
    localparam int SAMPLE_BITS = 24;

    typedef logic signed [SAMPLE_BITS-1:0] audio_sample_t;

    typedef struct packed {
        audio_sample_t left;
        audio_sample_t right;
    } audio_frame_t;

    // one full sine period, about half scale
    localparam int SINE_LEN   = 32;
    localparam int SINE_IDX_W = $clog2(SINE_LEN);

    localparam audio_sample_t SINE_TABLE [SINE_LEN] = '{
         24'sd0,        24'sd818267,   24'sd1605088,  24'sd2330229,
         24'sd2965821,  24'sd3487437,  24'sd3875033,  24'sd4113709,
         24'sd4194303,  24'sd4113709,  24'sd3875033,  24'sd3487437,
         24'sd2965821,  24'sd2330229,  24'sd1605088,  24'sd818267,
         24'sd0,       -24'sd818267,  -24'sd1605088, -24'sd2330229,
        -24'sd2965821, -24'sd3487437, -24'sd3875033, -24'sd4113709,
        -24'sd4194303, -24'sd4113709, -24'sd3875033, -24'sd3487437,
        -24'sd2965821, -24'sd2330229, -24'sd1605088, -24'sd818267
    };

    //////////////////////////////////////////////////
    // i2s timing
    //////////////////////////////////////////////////
    localparam int BCLK_DIV     = 4;
    localparam int SLOT_BITS    = 32;
    localparam int FRAME_CYCLES = BCLK_DIV * 2 * SLOT_BITS;
    localparam int FIFO_DEPTH   = 2;

    localparam int BCLK_PHASE_W = $clog2(BCLK_DIV);
    localparam int SLOT_POS_W   = $clog2(SLOT_BITS);
    localparam int FRAME_POS_W  = SLOT_POS_W + 1;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W   = $clog2(FIFO_DEPTH + 1);

endpackage

//--- design/codec_command_list.sv
`timescale 1ns/1ps

module codec_command_list (
    input  logic                  clk_soc,
    input  logic                  reset,
    input  logic                  ready,
    output codec_pkg::codec_cmd_u cmd,
    output logic                  cmd_valid,
    output logic                  init_done
);
    import codec_pkg::*;

    typedef enum logic [1:0] {
        LIST_START,
        LIST_SEND,
        LIST_DRAIN,
        LIST_DONE
    } list_state_t;

    list_state_t          state;
    logic [CMD_IDX_W-1:0] idx;

    // current table entry goes straight to the master
    assign cmd       = CMD_TABLE[idx];
    assign cmd_valid = (state == LIST_SEND);
    assign init_done = (state == LIST_DONE);

    always_ff @(posedge clk_soc or posedge reset) begin
        if (reset) begin
            state <= LIST_START;
            idx   <= '0;
        end else begin
            case (state)
                LIST_START: begin
                    state <= LIST_SEND;
                end

                // word moves on a cycle with valid and ready
                LIST_SEND: begin
                    if (ready) begin
                        if (idx == CMD_IDX_W'(CMD_COUNT - 1)) begin
                            state <= LIST_DRAIN;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end

                // last word still on the wire, wait out its latch gap
                LIST_DRAIN: begin
                    if (ready) begin
                        state <= LIST_DONE;
                    end
                end

                LIST_DONE: begin
                    state <= LIST_DONE;
                end

                default: begin
                    state <= LIST_START;
                end
            endcase
        end
    end

endmodule

//--- design/codec_spi_master.sv
`timescale 1ns/1ps

module codec_spi_master (
    input  logic                  clk_soc,
    input  logic                  reset,
    input  codec_pkg::codec_cmd_u cmd,
    input  logic                  cmd_valid,
    output logic                  ready,
    output logic                  cdata,
    output logic                  cclk,
    output logic                  clatch_n
);
    import codec_pkg::*;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_GAP
    } spi_state_t;

    spi_state_t              state;
    logic [CMD_BITS-1:0]     shift_reg;
    logic [CCLK_PHASE_W-1:0] phase;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [GAP_CNT_W-1:0]    gap_cnt;
    logic                    bit_end;

    assign ready   = (state == SPI_IDLE);
    assign bit_end = (state == SPI_SHIFT) && (phase == CCLK_PHASE_W'(CCLK_DIV - 1));

    //////////////////////////////////////////////////
    // state and pin registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_soc or posedge reset) begin
        if (reset) begin
            state    <= SPI_IDLE;
            phase    <= '0;
            bit_cnt  <= '0;
            gap_cnt  <= '0;
            clatch_n <= 1'b1;
            cclk     <= 1'b1;
            cdata    <= 1'b0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (cmd_valid) begin
                        state    <= SPI_SHIFT;
                        phase    <= '0;
                        bit_cnt  <= '0;
                        clatch_n <= 1'b0;
                        cclk     <= 1'b0;
                        cdata    <= cmd.raw[CMD_BITS-1];
                    end
                end

                // low half then high half of each cclk period
                SPI_SHIFT: begin
                    phase <= phase + 1'b1;
                    if (phase == CCLK_PHASE_W'(CCLK_DIV / 2 - 1)) begin
                        cclk <= 1'b1;
                    end
                    if (bit_end) begin
                        if (bit_cnt == BIT_CNT_W'(CMD_BITS - 1)) begin
                            state    <= SPI_GAP;
                            gap_cnt  <= '0;
                            clatch_n <= 1'b1;
                            cdata    <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            cclk    <= 1'b0;
                            cdata   <= shift_reg[CMD_BITS-2];
                        end
                    end
                end

                SPI_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_CNT_W'(LATCH_GAP - 1)) begin
                        state <= SPI_IDLE;
                    end
                end

                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    // msb first, next bit sits in bit CMD_BITS-2
    always_ff @(posedge clk_soc) begin
        if (ready && cmd_valid) begin
            shift_reg <= cmd.raw;
        end else if (bit_end) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

//--- design/sine_generator.sv
`timescale 1ns/1ps

module sine_generator (
    input  logic                     clk_soc,
    input  logic                     reset,
    input  logic                     ready,
    output logic                     valid,
    output audio_pkg::audio_sample_t sample
);
    import audio_pkg::*;

    logic [SINE_IDX_W-1:0] idx;
    logic [SINE_IDX_W-1:0] idx_next;
    logic [SINE_IDX_W-1:0] rd_idx;
    logic                  take;
    logic                  load;

    assign take = valid && ready;

    // wrap at the end of the period
    assign idx_next = (idx == SINE_IDX_W'(SINE_LEN - 1)) ? '0 : idx + 1'b1;

    // before valid, keep entry 0 ready; after a transfer, fetch the next one
    assign load   = !valid || take;
    assign rd_idx = valid ? idx_next : idx;

    //////////////////////////////////////////////////
    // phase index
    //////////////////////////////////////////////////
    always_ff @(posedge clk_soc or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
            idx   <= '0;
        end else begin
            valid <= 1'b1;
            if (take) begin
                idx <= idx_next;
            end
        end
    end

    // table read, held while the i2s side is full
    always_ff @(posedge clk_soc) begin
        if (load) begin
            sample <= SINE_TABLE[rd_idx];
        end
    end

endmodule

//--- design/i2s_master.sv
`timescale 1ns/1ps

module i2s_master (
    input  logic                    clk_soc,
    input  logic                    reset,
    input  audio_pkg::audio_frame_t frame,
    input  logic                    write_frame,
    output logic                    full,
    output logic                    mclk,
    output logic                    bclk,
    output logic                    lrclk,
    output logic                    sdata
);
    import audio_pkg::*;

    audio_frame_t            fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]   wr_ptr;
    logic [FIFO_PTR_W-1:0]   rd_ptr;
    logic [FIFO_CNT_W-1:0]   count;
    logic                    push;
    logic                    pop;

    logic [BCLK_PHASE_W-1:0] div;
    logic                    bclk_fall;
    logic [FRAME_POS_W-1:0]  pos;
    logic [FRAME_POS_W-1:0]  pos_next;
    logic [SLOT_POS_W-1:0]   slot_pos;
    logic                    lr_next;
    audio_frame_t            cur_frame;
    audio_sample_t           slot_sample;
    logic [SLOT_BITS-1:0]    shift_reg;

    assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign push      = write_frame && !full;
    assign bclk_fall = (div == BCLK_PHASE_W'(BCLK_DIV - 1));

    // position of the bit that starts at the coming bclk fall
    assign pos_next    = pos + 1'b1;
    assign slot_pos    = pos_next[SLOT_POS_W-1:0];
    assign lr_next     = pos_next[SLOT_POS_W];
    assign pop         = bclk_fall && (pos_next == '0) && (count != '0);
    assign slot_sample = lr_next ? cur_frame.right : cur_frame.left;

    //////////////////////////////////////////////////
    // two-frame buffer
    //////////////////////////////////////////////////
    always_ff @(posedge clk_soc or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_soc) begin
        if (push) begin
            fifo_mem[wr_ptr] <= frame;
        end
    end

    //////////////////////////////////////////////////
    // clocks and serializer
    //////////////////////////////////////////////////
    // pos starts at the last slot bit so the first fall opens a left slot
    always_ff @(posedge clk_soc or posedge reset) begin
        if (reset) begin
            mclk  <= 1'b0;
            div   <= '0;
            bclk  <= 1'b0;
            lrclk <= 1'b0;
            pos   <= '1;
            sdata <= 1'b0;
        end else begin
            mclk <= ~mclk;
            div  <= div + 1'b1;
            if (div == BCLK_PHASE_W'(BCLK_DIV / 2 - 1)) begin
                bclk <= 1'b1;
            end
            if (bclk_fall) begin
                bclk  <= 1'b0;
                pos   <= pos_next;
                lrclk <= lr_next;
                // i2s delay: msb one bclk after the lrclk edge
                if (slot_pos == '0) begin
                    sdata <= 1'b0;
                end else if (slot_pos == SLOT_POS_W'(1)) begin
                    sdata <= slot_sample[SAMPLE_BITS-1];
                end else begin
                    sdata <= shift_reg[SLOT_BITS-1];
                end
            end
        end
    end

    // empty buffer at a left slot start sends silence
    always_ff @(posedge clk_soc) begin
        if (bclk_fall) begin
            if (pos_next == '0) begin
                cur_frame <= (count != '0) ? fifo_mem[rd_ptr] : '0;
            end
            if (slot_pos == SLOT_POS_W'(1)) begin
                shift_reg <= {slot_sample[SAMPLE_BITS-2:0],
                              {(SLOT_BITS - SAMPLE_BITS + 1){1'b0}}};
            end else begin
                shift_reg <= shift_reg << 1;
            end
        end
    end

endmodule

//--- design/codec_standalone_top.sv
`timescale 1ns/1ps

module codec_standalone_top (
    input  logic       clk_soc,
    input  logic       btn_c,
    input  logic       btn_d,
    input  logic       btn_l,
    input  logic       btn_r,
    input  logic       btn_u,
    input  logic [7:0] dip,
    output logic [7:0] led,
    output logic [7:0] debug,
    output logic       ac_mclk,
    output logic       ac_addr0_clatch,
    output logic       ac_addr1_cdata,
    output logic       ac_scl_cclk,
    output logic       ac_dac_sdata,
    output logic       ac_bclk,
    output logic       ac_lrclk
);
    import codec_pkg::*;
    import audio_pkg::*;

    // power-up value holds the board in reset too
    logic [5:0]    rst_cnt = '1;
    logic          reset;

    codec_cmd_u    cmd;
    logic          cmd_valid;
    logic          spi_ready;

    audio_sample_t sample;
    audio_frame_t  frame;
    logic          gen_valid;
    logic          gen_ready;
    logic          audio_full;
    logic          write_frame;

    //////////////////////////////////////////////////
    // reset stretch
    //////////////////////////////////////////////////
    always_ff @(posedge clk_soc or posedge btn_c) begin
        if (btn_c) begin
            rst_cnt <= '1;
        end else if (|rst_cnt) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    assign reset = |rst_cnt;

    //////////////////////////////////////////////////
    // codec control port
    //////////////////////////////////////////////////
    // init_done is status only, no pin on this board
    codec_command_list u_cmd_list (
        .clk_soc   (clk_soc),
        .reset     (reset),
        .ready     (spi_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .init_done ()
    );

    codec_spi_master u_spi (
        .clk_soc   (clk_soc),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .ready     (spi_ready),
        .cdata     (ac_addr1_cdata),
        .cclk      (ac_scl_cclk),
        .clatch_n  (ac_addr0_clatch)
    );

    //////////////////////////////////////////////////
    // audio path
    //////////////////////////////////////////////////
    // same sample on both channels
    assign gen_ready   = !audio_full;
    assign write_frame = gen_valid && !audio_full;
    assign frame       = '{left: sample, right: sample};

    sine_generator u_sine (
        .clk_soc (clk_soc),
        .reset   (reset),
        .ready   (gen_ready),
        .valid   (gen_valid),
        .sample  (sample)
    );

    i2s_master u_i2s (
        .clk_soc     (clk_soc),
        .reset       (reset),
        .frame       (frame),
        .write_frame (write_frame),
        .full        (audio_full),
        .mclk        (ac_mclk),
        .bclk        (ac_bclk),
        .lrclk       (ac_lrclk),
        .sdata       (ac_dac_sdata)
    );

    // board glue
    assign led   = dip & {3'b111, btn_c, btn_d, btn_l, btn_r, btn_u};
    assign debug = {reset, ac_mclk, ac_addr0_clatch, ac_addr1_cdata,
                    ac_scl_cclk, ac_dac_sdata, ac_bclk, ac_lrclk};

endmodule

//--- dv/tb_codec_top.sv
`timescale 1ns/1ps

module tb_codec_top;
    import codec_pkg::*;
    import audio_pkg::*;

    localparam int WORD_CYCLES = CMD_BITS * CCLK_DIV + LATCH_GAP + 1;
    localparam int LED_ENTRIES = 16;
    localparam int STRETCH     = 63;
    localparam int AUDIO_FRAMES = 32;
    localparam int MAX_CYCLES  = CMD_COUNT * WORD_CYCLES + 40 * FRAME_CYCLES
                                 + LED_ENTRIES + 500;

    logic         clk_soc = 1'b0;
    logic         btn_c;
    logic         btn_d;
    logic         btn_l;
    logic         btn_r;
    logic         btn_u;
    logic [7:0]   dip;
    logic [7:0]   led;
    logic [7:0]   debug;
    logic         ac_mclk;
    logic         ac_addr0_clatch;
    logic         ac_addr1_cdata;
    logic         ac_scl_cclk;
    logic         ac_dac_sdata;
    logic         ac_bclk;
    logic         ac_lrclk;

    // captured traffic
    codec_cmd_u   words [$];
    audio_frame_t frames [$];
    logic [15:0]  pads [$];
    int           word_base = 0;
    int           frame_base = 0;

    // monitor state
    int                   cycle = 0;
    logic                 prev_rst;
    logic                 prev_clatch;
    logic                 prev_cclk;
    logic                 prev_bclk;
    logic                 prev_lrclk;
    logic                 prev_mclk;
    codec_cmd_u           cmd_cap;
    int                   cmd_bits;
    int                   gap_cycles;
    int                   windows = 0;
    int                   gap_bad = 0;
    logic [SLOT_BITS-1:0] slot_shift;
    logic [SLOT_BITS-1:0] slot_word;
    logic [SLOT_BITS-1:0] left_word;
    int                   slot_pos;
    int                   slot_bits;
    logic                 last_lr;
    logic                 lr_edge;
    logic                 first_slot;
    logic                 have_left;
    audio_frame_t         frame_cap;
    int                   mclk_bad = 0;
    int                   lr_bad = 0;
    int                   debug_bad = 0;
    logic                 lr_rise_valid;
    int                   lr_rise_cycle;

    // test bookkeeping
    int           errors = 0;
    int           checks = 0;
    int           tests_done = 0;
    int           test_err_base = 0;
    int           want_words = 0;
    int           want_frames = 0;
    string        waiting_for = "start";
    logic [15:0]  lfsr_state = 16'd47766;
    logic [7:0]   led_dip [LED_ENTRIES];
    logic [3:0]   led_btn [LED_ENTRIES];
    logic [7:0]   led_exp [LED_ENTRIES];

    codec_standalone_top dut0 (
        .clk_soc         (clk_soc),
        .btn_c           (btn_c),
        .btn_d           (btn_d),
        .btn_l           (btn_l),
        .btn_r           (btn_r),
        .btn_u           (btn_u),
        .dip             (dip),
        .led             (led),
        .debug           (debug),
        .ac_mclk         (ac_mclk),
        .ac_addr0_clatch (ac_addr0_clatch),
        .ac_addr1_cdata  (ac_addr1_cdata),
        .ac_scl_cclk     (ac_scl_cclk),
        .ac_dac_sdata    (ac_dac_sdata),
        .ac_bclk         (ac_bclk),
        .ac_lrclk        (ac_lrclk)
    );

    always #50 clk_soc = ~clk_soc;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %t: %s", $time, msg);
    endtask

    task automatic compare_cmd(input int idx, input codec_cmd_u got, input codec_cmd_u exp);
        checks++;
        if (got.f.chip_addr !== exp.f.chip_addr) begin
            report_error($sformatf("word %0d chip address %h, expected %h",
                                   idx, got.f.chip_addr, exp.f.chip_addr));
        end
        if (got.f.reg_addr !== exp.f.reg_addr) begin
            report_error($sformatf("word %0d register %h, expected %h",
                                   idx, got.f.reg_addr, exp.f.reg_addr));
        end
        if (got.f.data !== exp.f.data) begin
            report_error($sformatf("word %0d data %h, expected %h",
                                   idx, got.f.data, exp.f.data));
        end
    endtask

    task automatic compare_sample(input string what, input audio_sample_t got,
                                  input audio_sample_t exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic compare_led(input int idx, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("led entry %0d is %b, expected %b", idx, got, exp));
        end
    endtask

    task automatic compare_pin(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_idle_pins(input string when);
        compare_pin({"clatch_n ", when}, ac_addr0_clatch, 1'b1);
        compare_pin({"cclk ", when}, ac_scl_cclk, 1'b1);
        compare_pin({"cdata ", when}, ac_addr1_cdata, 1'b0);
        compare_pin({"sdata ", when}, ac_dac_sdata, 1'b0);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s done, %0d errors", tests_done, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic build_led_table();
        logic [7:0] d;
        for (int i = 0; i < LED_ENTRIES; i++) begin
            d = '0;
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                d = {d[6:0], lfsr_state[0]};
            end
            led_dip[i] = d;
            led_btn[i] = 4'(i);
            // buttons c, d, l, r, u under three always-on bits
            led_exp[i] = d & {3'b111, 1'b0, 4'(i)};
        end
    endtask

    //////////////////////////////////////////////////
    // control port and i2s monitors
    //////////////////////////////////////////////////
    always @(posedge clk_soc) begin
        cycle++;
        // debug port mirrors the codec pins below the reset bit
        if (debug[6:0] !== {ac_mclk, ac_addr0_clatch, ac_addr1_cdata, ac_scl_cclk,
                            ac_dac_sdata, ac_bclk, ac_lrclk}) begin
            debug_bad++;
        end
        if (debug[7]) begin
            cmd_bits      = 0;
            gap_cycles    = 1000;
            // first bclk high phase after reset is the tail of a right slot
            slot_pos      = SLOT_BITS - 2;
            slot_bits     = 0;
            last_lr       = 1'b0;
            first_slot    = 1'b1;
            have_left     = 1'b0;
            lr_rise_valid = 1'b0;
        end else begin
            if (!ac_addr0_clatch && prev_clatch) begin
                windows++;
                if (gap_cycles < LATCH_GAP) begin
                    gap_bad++;
                end
                gap_cycles = 0;
                cmd_bits   = 0;
            end
            if (ac_addr0_clatch) begin
                gap_cycles++;
            end
            if (!ac_addr0_clatch && ac_scl_cclk && !prev_cclk) begin
                cmd_cap.raw = {cmd_cap.raw[CMD_BITS-2:0], ac_addr1_cdata};
                cmd_bits++;
            end
            // partial words are dropped
            if (ac_addr0_clatch && !prev_clatch) begin
                if (cmd_bits == CMD_BITS) begin
                    words.push_back(cmd_cap);
                end
                cmd_bits = 0;
            end

            if (!prev_rst && ac_mclk == prev_mclk) begin
                mclk_bad++;
            end
            if (ac_lrclk && !prev_lrclk) begin
                if (lr_rise_valid && cycle - lr_rise_cycle != FRAME_CYCLES) begin
                    lr_bad++;
                end
                lr_rise_valid = 1'b1;
                lr_rise_cycle = cycle;
            end

            // slot word: bits 1..31 of a slot, then bit 0 of the next one
            if (ac_bclk && !prev_bclk) begin
                slot_word  = {slot_shift[SLOT_BITS-2:0], ac_dac_sdata};
                slot_shift = slot_word;
                lr_edge    = (ac_lrclk != last_lr);
                if (lr_edge || slot_pos == SLOT_BITS - 1) begin
                    if (!first_slot && (lr_edge != (slot_pos == SLOT_BITS - 1))) begin
                        lr_bad++;
                    end
                    if (slot_bits == SLOT_BITS - 1) begin
                        if (!last_lr) begin
                            left_word = slot_word;
                            have_left = 1'b1;
                        end else if (have_left) begin
                            frame_cap.left  = left_word[SLOT_BITS-1 -: SAMPLE_BITS];
                            frame_cap.right = slot_word[SLOT_BITS-1 -: SAMPLE_BITS];
                            frames.push_back(frame_cap);
                            pads.push_back({left_word[7:0], slot_word[7:0]});
                            have_left = 1'b0;
                        end
                    end
                    first_slot = 1'b0;
                    slot_pos   = 0;
                    slot_bits  = 0;
                end else begin
                    slot_pos++;
                    slot_bits++;
                end
                last_lr = ac_lrclk;
            end
        end
        prev_rst    = debug[7];
        prev_clatch = ac_addr0_clatch;
        prev_cclk   = ac_scl_cclk;
        prev_bclk   = ac_bclk;
        prev_lrclk  = ac_lrclk;
        prev_mclk   = ac_mclk;
    end

    always @(posedge clk_soc) begin
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles while waiting for %s", cycle, waiting_for);
            $display("got %0d of %0d control words and %0d of %0d audio frames",
                     words.size() - word_base, want_words,
                     frames.size() - frame_base, want_frames);
            $display("tests done %0d, checks %0d, errors %0d", tests_done, checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        int n;
        $timeformat(-9, 0, " ns", 0);
        btn_c = 1'b1;
        btn_d = 1'b0;
        btn_l = 1'b0;
        btn_r = 1'b0;
        btn_u = 1'b0;
        dip   = 8'h00;
        build_led_table();

        waiting_for = "reset release";
        repeat (2) @(posedge clk_soc);
        compare_pin("reset during btn_c", debug[7], 1'b1);
        check_idle_pins("in reset");
        repeat (3) @(posedge clk_soc);
        btn_c <= 1'b0;
        n = 0;
        @(posedge clk_soc);
        while (debug[7]) begin
            n++;
            @(posedge clk_soc);
        end
        check_count("reset stretch cycles", n, STRETCH);
        check_idle_pins("after reset");
        finish_test("reset state");

        // pulse btn_c in the middle of word 5
        waiting_for = "command word 5";
        want_words  = 5;
        while (words.size() < 5 || ac_addr0_clatch) begin
            @(posedge clk_soc);
        end
        repeat (40) @(posedge clk_soc);
        btn_c <= 1'b1;
        repeat (2) @(posedge clk_soc);
        btn_c <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            compare_cmd(i, words[i], CMD_TABLE[i]);
        end
        @(posedge clk_soc);
        while (debug[7]) begin
            @(posedge clk_soc);
        end
        check_count("words captured before restart", words.size(), 5);
        word_base   = words.size();
        frame_base  = frames.size();
        n           = windows;
        waiting_for = "first frame after restart";
        want_frames = 1;
        while (frames.size() < frame_base + 1) begin
            @(posedge clk_soc);
        end
        compare_sample("left of first frame", frames[frame_base].left, SINE_TABLE[0]);
        compare_sample("right of first frame", frames[frame_base].right, SINE_TABLE[0]);
        finish_test("mid-run reset");

        waiting_for = "command sequence";
        want_words  = CMD_COUNT;
        while (words.size() < word_base + CMD_COUNT) begin
            @(posedge clk_soc);
        end
        for (int i = 0; i < CMD_COUNT; i++) begin
            compare_cmd(i, words[word_base + i], CMD_TABLE[i]);
        end
        check_count("short latch gaps", gap_bad, 0);
        finish_test("command sequence");

        waiting_for = "audio frames";
        want_frames = AUDIO_FRAMES;
        while (frames.size() < frame_base + AUDIO_FRAMES) begin
            @(posedge clk_soc);
        end
        for (int k = 0; k < AUDIO_FRAMES; k++) begin
            compare_sample($sformatf("left of frame %0d", k),
                           frames[frame_base + k].left, SINE_TABLE[k % SINE_LEN]);
            compare_sample($sformatf("right of frame %0d", k),
                           frames[frame_base + k].right, SINE_TABLE[k % SINE_LEN]);
            check_count($sformatf("padding of frame %0d", k), int'(pads[frame_base + k]), 0);
        end
        check_count("missed mclk toggles", mclk_bad, 0);
        check_count("bad lrclk periods or slot edges", lr_bad, 0);
        finish_test("audio stream");

        // whole audio run has passed since the last word
        check_count("latch windows after restart", windows - n, CMD_COUNT);
        check_count("words after restart", words.size() - word_base, CMD_COUNT);
        finish_test("init completion");

        waiting_for = "led table";
        for (int i = 0; i < LED_ENTRIES; i++) begin
            @(posedge clk_soc);
            dip <= led_dip[i];
            {btn_d, btn_l, btn_r, btn_u} <= led_btn[i];
            @(posedge clk_soc);
            compare_led(i, led, led_exp[i]);
        end
        {btn_d, btn_l, btn_r, btn_u} <= 4'b0000;
        check_count("debug port mismatches", debug_bad, 0);
        finish_test("led glue");

        $display("tests done %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- all.f
design/codec_pkg.sv
design/audio_pkg.sv
design/codec_command_list.sv
design/codec_spi_master.sv
design/sine_generator.sv
design/i2s_master.sv
design/codec_standalone_top.sv
dv/tb_codec_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_codec_top
RTL_TOP    := codec_standalone_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^PASS: all tests$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
